// ==== cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top #(
    parameter int IMEM_DEPTH = 256,
    parameter int IB_DEPTH   = 8      // Even, at least 4
) (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic                            halt_i,
    // Program load
    input  logic                            load_we_i,
    input  logic [$clog2(IMEM_DEPTH)-1:0]   load_addr_i,
    input  pipe_pkg::word_t                 load_data_i,
    // Commit report
    output logic [1:0]                      commit_valid_o,
    output pipe_pkg::word_t [1:0]           commit_pc_o,
    output logic [1:0]                      commit_wen_o,
    output pipe_pkg::reg_addr_t [1:0]       commit_wnum_o,
    output pipe_pkg::word_t [1:0]           commit_wdata_o
);
    import pipe_pkg::*;

    logic                         fetch_req;
    word_t                        fetch_pc;
    logic                         inst_valid;
    word_t [FETCH_WIDTH-1:0]      inst_word;
    logic                         ib_full;
    logic                         ib_push;
    ib_entry_t [FETCH_WIDTH-1:0]  ib_push_entry;
    logic [1:0]                   pop_valid;
    ib_entry_t [1:0]              pop_entry;
    logic [1:0]                   pop_take;
    logic                         flush;        // Taken branch
    word_t                        redirect_pc;

    inst_mem #(
        .IMEM_DEPTH(IMEM_DEPTH)
    ) u_inst_mem (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .load_we_i   (load_we_i),
        .load_addr_i (load_addr_i),
        .load_data_i (load_data_i),
        .fetch_req_i (fetch_req),
        .fetch_pc_i  (fetch_pc),
        .inst_valid_o(inst_valid),
        .inst_word_o (inst_word)
    );

    fetch_frontend u_fetch_frontend (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .inst_valid_i   (inst_valid),
        .inst_word_i    (inst_word),
        .ib_full_i      (ib_full),
        .flush_i        (flush),
        .redirect_pc_i  (redirect_pc),
        .fetch_req_o    (fetch_req),
        .fetch_pc_o     (fetch_pc),
        .ib_push_o      (ib_push),
        .ib_push_entry_o(ib_push_entry)
    );

    instr_buffer #(
        .IB_DEPTH(IB_DEPTH)
    ) u_instr_buffer (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .push_i      (ib_push),
        .push_entry_i(ib_push_entry),
        .pop_take_i  (pop_take),
        .flush_i     (flush),
        .ib_full_o   (ib_full),
        .pop_valid_o (pop_valid),
        .pop_entry_o (pop_entry)
    );

    issue_commit u_issue_commit (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .halt_i        (halt_i),
        .pop_valid_i   (pop_valid),
        .pop_entry_i   (pop_entry),
        .pop_take_o    (pop_take),
        .flush_o       (flush),
        .redirect_pc_o (redirect_pc),
        .commit_valid_o(commit_valid_o),
        .commit_pc_o   (commit_pc_o),
        .commit_wen_o  (commit_wen_o),
        .commit_wnum_o (commit_wnum_o),
        .commit_wdata_o(commit_wdata_o)
    );

endmodule

// ==== fetch_frontend.sv ====
`timescale 1ns/1ps

module fetch_frontend (
    input  logic                                            clk,
    input  logic                                            rst_n_i,
    // Memory response
    input  logic                                            inst_valid_i,
    input  pipe_pkg::word_t [pipe_pkg::FETCH_WIDTH-1:0]     inst_word_i,
    // Buffer and backend
    input  logic                                            ib_full_i,
    input  logic                                            flush_i,
    input  pipe_pkg::word_t                                 redirect_pc_i,
    // Memory request
    output logic                                            fetch_req_o,
    output pipe_pkg::word_t                                 fetch_pc_o,
    // Buffer push
    output logic                                            ib_push_o,
    output pipe_pkg::ib_entry_t [pipe_pkg::FETCH_WIDTH-1:0] ib_push_entry_o
);
    import pipe_pkg::*;

    logic  fetch_en_q;    // Low for the first cycle out of reset
    word_t pc_q;
    word_t req_pc_q;      // Slot 0 pc of the outstanding request
    logic  stale_q;       // Response in flight belongs to a flushed path

    assign fetch_req_o = fetch_en_q && !ib_full_i;
    assign fetch_pc_o  = pc_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            fetch_en_q <= 1'b0;
        end else begin
            fetch_en_q <= 1'b1;
        end
    end

    // Redirect has priority over the sequential advance
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q <= '0;
        end else if (flush_i) begin
            pc_q <= redirect_pc_i;
        end else if (fetch_req_o) begin
            pc_q <= pc_q + word_t'(4 * FETCH_WIDTH);
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_req_o) begin
            req_pc_q <= pc_q;
        end
    end

    // A request issued during a flush still fetches the old path
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            stale_q <= 1'b0;
        end else begin
            stale_q <= flush_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ib_push_o <= 1'b0;
        end else begin
            ib_push_o <= inst_valid_i && !stale_q && !flush_i;
        end
    end

    // Pair returned words with their pcs
    always_ff @(posedge clk) begin
        if (inst_valid_i) begin
            for (int k = 0; k < FETCH_WIDTH; k++) begin
                ib_push_entry_o[k].pc   <= req_pc_q + word_t'(4 * k);
                ib_push_entry_o[k].inst <= inst_word_i[k];
            end
        end
    end

endmodule

// ==== flist.f ====
pipe_pkg.sv
inst_mem.sv
fetch_frontend.sv
instr_buffer.sv
issue_commit.sv
cpu_top.sv
tb_cpu_top.sv

// ==== inst_mem.sv ====
`timescale 1ns/1ps

module inst_mem #(
    parameter int IMEM_DEPTH = 256
) (
    input  logic                                         clk,
    input  logic                                         rst_n_i,
    input  logic                                         load_we_i,
    input  logic [$clog2(IMEM_DEPTH)-1:0]                load_addr_i,
    input  pipe_pkg::word_t                              load_data_i,
    input  logic                                         fetch_req_i,
    input  pipe_pkg::word_t                              fetch_pc_i,
    output logic                                         inst_valid_o,
    output pipe_pkg::word_t [pipe_pkg::FETCH_WIDTH-1:0]  inst_word_o
);
    import pipe_pkg::*;

    localparam int AW = $clog2(IMEM_DEPTH);

    word_t         mem [IMEM_DEPTH];
    logic [AW-1:0] rd_idx [FETCH_WIDTH];

    // Word index of each slot, wrapping at the memory size
    always_comb begin
        word_t waddr;
        for (int k = 0; k < FETCH_WIDTH; k++) begin
            waddr = (fetch_pc_i >> 2) + word_t'(k);
            rd_idx[k] = AW'(waddr % IMEM_DEPTH);
        end
    end

    always_ff @(posedge clk) begin
        if (load_we_i) begin
            mem[load_addr_i] <= load_data_i;    // Program load port
        end
        if (fetch_req_i) begin
            for (int k = 0; k < FETCH_WIDTH; k++) begin
                inst_word_o[k] <= mem[rd_idx[k]];
            end
        end
    end

    // Response one cycle after the request
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            inst_valid_o <= 1'b0;
        end else begin
            inst_valid_o <= fetch_req_i;
        end
    end

endmodule

// ==== instr_buffer.sv ====
`timescale 1ns/1ps

module instr_buffer #(
    parameter int IB_DEPTH = 8
) (
    input  logic                                            clk,
    input  logic                                            rst_n_i,
    input  logic                                            push_i,
    input  pipe_pkg::ib_entry_t [pipe_pkg::FETCH_WIDTH-1:0] push_entry_i,
    input  logic [1:0]                                      pop_take_i,
    input  logic                                            flush_i,
    output logic                                            ib_full_o,
    output logic [1:0]                                      pop_valid_o,
    output pipe_pkg::ib_entry_t [1:0]                       pop_entry_o
);
    import pipe_pkg::*;

    localparam int PW = $clog2(IB_DEPTH);
    localparam int CW = $clog2(IB_DEPTH + 1);

    ib_entry_t     buf_q [IB_DEPTH];
    logic [PW-1:0] head_q;
    logic [PW-1:0] tail_q;
    logic [CW-1:0] count_q;
    logic [CW-1:0] count_d;
    logic [1:0]    n_pop;

    // Pointer advance that wraps at any depth
    function automatic logic [PW-1:0] ptr_add(logic [PW-1:0] ptr, int unsigned n);
        int unsigned sum;
        sum = ptr + n;
        if (sum >= IB_DEPTH) begin
            sum = sum - IB_DEPTH;
        end
        return PW'(sum);
    endfunction

    // Slot 1 is only taken together with slot 0
    always_comb begin
        n_pop = 2'd0;
        if (pop_take_i[0]) begin
            n_pop = pop_take_i[1] ? 2'd2 : 2'd1;
        end
    end

    always_comb begin
        if (flush_i) begin
            count_d = '0;
        end else begin
            count_d = count_q + (push_i ? CW'(FETCH_WIDTH) : CW'(0)) - CW'(n_pop);
        end
    end

    // Room left after this cycle must hold the two pairs still in flight
    assign ib_full_o = (IB_DEPTH - int'(count_d)) < (2 * FETCH_WIDTH);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            count_q <= count_d;
            if (flush_i) begin
                head_q <= tail_q;    // Drop everything queued
            end else begin
                head_q <= ptr_add(head_q, 32'(n_pop));
                if (push_i) begin
                    tail_q <= ptr_add(tail_q, FETCH_WIDTH);
                end
            end
        end
    end

    // A push during a flush is not stored
    always_ff @(posedge clk) begin
        if (push_i && !flush_i) begin
            for (int k = 0; k < FETCH_WIDTH; k++) begin
                buf_q[ptr_add(tail_q, k)] <= push_entry_i[k];
            end
        end
    end

    assign pop_valid_o[0] = (count_q != '0);
    assign pop_valid_o[1] = (count_q >= CW'(2));
    assign pop_entry_o[0] = buf_q[head_q];
    assign pop_entry_o[1] = buf_q[ptr_add(head_q, 1)];

endmodule

// ==== issue_commit.sv ====
`timescale 1ns/1ps

module issue_commit (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic                            halt_i,
    // Buffer head
    input  logic [1:0]                      pop_valid_i,
    input  pipe_pkg::ib_entry_t [1:0]       pop_entry_i,
    output logic [1:0]                      pop_take_o,
    // Redirect to fetch and buffer
    output logic                            flush_o,
    output pipe_pkg::word_t                 redirect_pc_o,
    // Commit report, one channel per slot
    output logic [1:0]                      commit_valid_o,
    output pipe_pkg::word_t [1:0]           commit_pc_o,
    output logic [1:0]                      commit_wen_o,
    output pipe_pkg::reg_addr_t [1:0]       commit_wnum_o,
    output pipe_pkg::word_t [1:0]           commit_wdata_o
);
    import pipe_pkg::*;

    localparam int NUM_REGS = 1 << REG_ADDR_W;

    word_t      rf_q [NUM_REGS];
    opcode_t    op [2];
    reg_addr_t  rd [2];
    reg_addr_t  rj [2];
    word_t      rj_val [2];
    word_t      result [2];
    word_t      target [2];
    logic [1:0] is_addi;
    logic [1:0] is_br;
    logic [1:0] wen;
    logic [1:0] take;

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            op[s]      = get_opcode(pop_entry_i[s].inst);
            rd[s]      = get_rd(pop_entry_i[s].inst);
            rj[s]      = get_rj(pop_entry_i[s].inst);
            is_addi[s] = (op[s] == OP_ADDI);
            is_br[s]   = (op[s] == OP_B);
            wen[s]     = is_addi[s] && (rd[s] != '0);    // r0 stays zero
            target[s]  = pop_entry_i[s].pc + br_offset(pop_entry_i[s].inst);
        end

        rj_val[0] = rf_q[rj[0]];
        result[0] = rj_val[0] + imm12_sext(pop_entry_i[0].inst);

        // In-pair forwarding from slot 0
        if (wen[0] && (rj[1] == rd[0])) begin
            rj_val[1] = result[0];
        end else begin
            rj_val[1] = rf_q[rj[1]];
        end
        result[1] = rj_val[1] + imm12_sext(pop_entry_i[1].inst);
    end

    // A branch in slot 0 cancels slot 1
    always_comb begin
        take[0] = pop_valid_i[0] && !halt_i;
        take[1] = take[0] && pop_valid_i[1] && !is_br[0];
    end

    assign pop_take_o    = take;
    assign flush_o       = (take[0] && is_br[0]) || (take[1] && is_br[1]);
    assign redirect_pc_o = is_br[0] ? target[0] : target[1];

    // Slot 1 written last so it wins on the same rd
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                rf_q[r] <= '0;
            end
        end else begin
            for (int s = 0; s < 2; s++) begin
                if (take[s] && wen[s]) begin
                    rf_q[rd[s]] <= result[s];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            commit_valid_o <= '0;
            commit_wen_o   <= '0;
        end else begin
            commit_valid_o <= take;
            commit_wen_o   <= take & wen;
        end
    end

    always_ff @(posedge clk) begin
        for (int s = 0; s < 2; s++) begin
            if (take[s]) begin
                commit_pc_o[s]    <= pop_entry_i[s].pc;
                commit_wnum_o[s]  <= is_addi[s] ? rd[s] : '0;
                commit_wdata_o[s] <= is_addi[s] ? result[s] : '0;
            end
        end
    end

endmodule

// ==== pipe_pkg.sv ====
package pipe_pkg;

    localparam int XLEN        = 32;
    localparam int FETCH_WIDTH = 2;    // Instructions per fetch pair
    localparam int REG_ADDR_W  = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // Instruction field positions
    localparam int OPCODE_LSB = 26;    // Opcode in the top six bits
    localparam int RD_LSB     = 0;
    localparam int RJ_LSB     = 5;
    localparam int IMM12_LSB  = 10;    // Sits just above rj
    localparam int IMM16_LSB  = 10;    // Bits 25..10

    typedef enum logic [5:0] {
        OP_NOP  = 6'h00,
        OP_ADDI = 6'h0a,
        OP_B    = 6'h14
    } opcode_t;

    typedef struct packed {
        word_t pc;
        word_t inst;
    } ib_entry_t;

    // Unknown opcodes decode as NOP
    function automatic opcode_t get_opcode(word_t inst);
        logic [5:0] op;
        op = inst[XLEN-1:OPCODE_LSB];
        case (op)
            OP_ADDI: return OP_ADDI;
            OP_B:    return OP_B;
            default: return OP_NOP;
        endcase
    endfunction

    function automatic reg_addr_t get_rd(word_t inst);
        return inst[RD_LSB +: REG_ADDR_W];
    endfunction

    function automatic reg_addr_t get_rj(word_t inst);
        return inst[RJ_LSB +: REG_ADDR_W];
    endfunction

    function automatic word_t imm12_sext(word_t inst);
        logic [11:0] imm;
        imm = inst[IMM12_LSB +: 12];
        return {{(XLEN-12){imm[11]}}, imm};
    endfunction

    // Branch offset in bytes, word aligned
    function automatic word_t br_offset(word_t inst);
        logic [15:0] off;
        off = inst[IMM16_LSB +: 16];
        return {{(XLEN-18){off[15]}}, off, 2'b00};
    endfunction

endpackage

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the cpu_top testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tb_cpu_top \
    -Mdir obj_dir -o tb_cpu_top > build.log 2>&1 \
    && ./obj_dir/tb_cpu_top > sim.log 2>&1 \
    || { echo "Build or simulation failed, see build.log and sim.log"; exit 1; }

grep -q "Simulation finished: PASS" sim.log \
    && { echo "Result: pass"; exit 0; } \
    || { echo "Result: fail, see sim.log"; exit 1; }

// ==== tb_cpu_top.sv ====
`timescale 1ns/1ps

module tb_cpu_top;
    import pipe_pkg::*;

    localparam int IMEM_DEPTH     = 256;
    localparam int AW             = $clog2(IMEM_DEPTH);
    localparam int NUM_ROWS       = 24;
    localparam int LOOP_PASSES    = 8;
    localparam int EXP_COMMITS    = 16 + 4 * LOOP_PASSES;    // Straight-line rows plus the loop
    localparam int RST_CYCLES     = 4;
    localparam int HALT_CYCLES    = 30;
    localparam int HALT_AFTER     = 10;                       // Commits seen before halt goes high
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 40 + HALT_CYCLES + NUM_ROWS + RST_CYCLES;
    localparam logic [5:0] OP_OTHER = 6'h3f;                  // Unknown opcode that runs as NOP

    logic                clk;
    logic                rst_n_i;
    logic                halt_i;
    logic                load_we_i;
    logic [AW-1:0]       load_addr_i;
    word_t               load_data_i;
    logic [1:0]          commit_valid_o;
    word_t [1:0]         commit_pc_o;
    logic [1:0]          commit_wen_o;
    reg_addr_t [1:0]     commit_wnum_o;
    word_t [1:0]         commit_wdata_o;

    // Program table
    logic [5:0]  row_op  [NUM_ROWS];
    reg_addr_t   row_rd  [NUM_ROWS];
    reg_addr_t   row_rj  [NUM_ROWS];
    logic [15:0] row_imm [NUM_ROWS];

    // Expected commit sequence
    word_t       exp_pc      [EXP_COMMITS];
    logic        exp_wen     [EXP_COMMITS];
    reg_addr_t   exp_wnum    [EXP_COMMITS];
    word_t       exp_wdata   [EXP_COMMITS];
    logic        exp_is_addi [EXP_COMMITS];

    logic [31:0] rng_state;
    int          errors    = 0;
    int          obs_count = 0;
    int          rst_seen  = 0;
    logic        halt_prev = 1'b0;

    cpu_top #(
        .IMEM_DEPTH(IMEM_DEPTH),
        .IB_DEPTH  (8)
    ) i_cpu_top (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .halt_i        (halt_i),
        .load_we_i     (load_we_i),
        .load_addr_i   (load_addr_i),
        .load_data_i   (load_data_i),
        .commit_valid_o(commit_valid_o),
        .commit_pc_o   (commit_pc_o),
        .commit_wen_o  (commit_wen_o),
        .commit_wnum_o (commit_wnum_o),
        .commit_wdata_o(commit_wdata_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic int rand_imm12();
        logic [31:0] r;
        r = next_random();
        return int'($signed(r[11:0]));
    endfunction

    task automatic set_row(int i, logic [5:0] op, int rd, int rj, int imm);
        row_op[i]  = op;
        row_rd[i]  = reg_addr_t'(rd);
        row_rj[i]  = reg_addr_t'(rj);
        row_imm[i] = 16'(imm);
    endtask

    // ADDI packs op, imm12, rj and rd, B packs op and imm16
    function automatic word_t encode_row(int i);
        word_t w;
        w = '0;
        w[31:26] = row_op[i];
        if (row_op[i] == 6'(OP_B)) begin
            w[25:10] = row_imm[i];
        end else begin
            w[21:10] = row_imm[i][11:0];
            w[9:5]   = row_rj[i];
            w[4:0]   = row_rd[i];
        end
        return w;
    endfunction

    task automatic build_table();
        set_row(0,  OP_ADDI, 1,  0, rand_imm12());
        set_row(1,  OP_ADDI, 2,  1, rand_imm12());    // Depends on its pair partner
        set_row(2,  OP_ADDI, 3,  2, rand_imm12());
        set_row(3,  OP_ADDI, 3,  3, rand_imm12());
        set_row(4,  OP_ADDI, 0,  3, rand_imm12());    // Write to r0 is dropped
        set_row(5,  OP_ADDI, 4,  0, 5);
        set_row(6,  OP_B,    0,  0, 2);               // Jumps forward to row 8
        set_row(7,  OP_ADDI, 5,  0, 111);
        set_row(8,  OP_ADDI, 6,  0, 222);
        set_row(9,  OP_ADDI, 5,  4, rand_imm12());
        set_row(10, OP_ADDI, 6,  5, rand_imm12());
        set_row(11, OP_B,    0,  0, 4);               // Lands in slot 1 and jumps to row 15
        set_row(12, OP_ADDI, 10, 0, 1);
        set_row(13, OP_ADDI, 11, 0, 2);
        set_row(14, OP_ADDI, 12, 0, 3);
        set_row(15, OP_OTHER, 0, 0, 0);
        set_row(16, OP_ADDI, 0,  0, rand_imm12());
        set_row(17, OP_ADDI, 13, 0, rand_imm12());    // r0 must still read zero
        set_row(18, OP_ADDI, 7,  0, 0);
        set_row(19, OP_ADDI, 8,  6, rand_imm12());
        set_row(20, OP_ADDI, 8,  8, rand_imm12());    // Loop body starts here
        set_row(21, OP_ADDI, 9,  8, 1);
        set_row(22, OP_ADDI, 7,  7, 1);               // Pass counter
        set_row(23, OP_B,    0,  0, -3);              // Back to row 20
    endtask

    // Reference model walks the table row by row
    task automatic build_expected();
        word_t       regs [32];
        int          idx;
        int          n;
        logic [11:0] imm12;
        word_t       val;
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        idx = 0;
        n   = 0;
        while (n < EXP_COMMITS) begin
            if (idx < 0 || idx >= NUM_ROWS) begin
                $display("Reference model walked off the program at row %0d", idx);
                errors++;
                break;
            end
            exp_pc[n]      = word_t'(idx * 4);
            exp_wen[n]     = 1'b0;
            exp_wnum[n]    = '0;
            exp_wdata[n]   = '0;
            exp_is_addi[n] = 1'b0;
            if (row_op[idx] == 6'(OP_ADDI)) begin
                imm12 = row_imm[idx][11:0];
                val   = ((row_rj[idx] == '0) ? '0 : regs[row_rj[idx]]) + {{20{imm12[11]}}, imm12};
                exp_is_addi[n] = 1'b1;
                exp_wen[n]     = (row_rd[idx] != '0);
                exp_wnum[n]    = row_rd[idx];
                exp_wdata[n]   = val;
                if (row_rd[idx] != '0) begin
                    regs[row_rd[idx]] = val;
                end
                idx++;
            end else if (row_op[idx] == 6'(OP_B)) begin
                idx = idx + int'($signed(row_imm[idx]));    // Offset counts words
            end else begin
                idx++;
            end
            n++;
        end
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_reg(string name, reg_addr_t got, reg_addr_t exp);
        if (got !== exp) begin
            $display("Error at %0t: %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("Error at %0t: %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_commit(int s);
        int i;
        i = obs_count;
        if (i < EXP_COMMITS) begin
            check_word($sformatf("commit_pc_o[%0d] #%0d", s, i), commit_pc_o[s], exp_pc[i]);
            check_bit($sformatf("commit_wen_o[%0d] #%0d", s, i), commit_wen_o[s], exp_wen[i]);
            if (exp_is_addi[i]) begin
                check_reg($sformatf("commit_wnum_o[%0d] #%0d", s, i), commit_wnum_o[s],
                          exp_wnum[i]);
            end
            if (exp_wen[i]) begin
                check_word($sformatf("commit_wdata_o[%0d] #%0d", s, i), commit_wdata_o[s],
                           exp_wdata[i]);
            end
        end
        obs_count++;
    endtask

    // Commit monitor checks slot 0 before slot 1
    always @(posedge clk) begin
        if (!rst_n_i) begin
            rst_seen++;
            if (rst_seen > 1 && commit_valid_o !== 2'b00) begin
                $display("commit_valid_o was not low during reset at %0t", $time);
                errors++;
            end
        end else if ($isunknown(commit_valid_o)) begin
            $display("commit_valid_o was unknown after reset at %0t", $time);
            errors++;
        end else begin
            if (halt_prev && commit_valid_o != 2'b00) begin
                $display("An instruction committed while halt was high at %0t", $time);
                errors++;
            end
            if (commit_valid_o[1] && !commit_valid_o[0]) begin
                $display("Slot 1 committed without slot 0 at %0t", $time);
                errors++;
            end
            for (int s = 0; s < 2; s++) begin
                if (commit_valid_o[s]) begin
                    check_commit(s);
                end
            end
        end
        halt_prev = halt_i;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: the expected commits did not all arrive, %0d of %0d seen",
                 obs_count, EXP_COMMITS);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        rst_n_i     = 1'b0;
        halt_i      = 1'b0;
        load_we_i   = 1'b0;
        load_addr_i = '0;
        load_data_i = '0;
        rng_state   = 32'h5a4a78ce;
        build_table();
        build_expected();

        // Program goes in while the core is held in reset
        for (int i = 0; i < NUM_ROWS; i++) begin
            @(posedge clk);
            #2;
            load_we_i   = 1'b1;
            load_addr_i = AW'(i);
            load_data_i = encode_row(i);
        end
        @(posedge clk);
        #2;
        load_we_i = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #2;
        rst_n_i = 1'b1;

        wait (obs_count >= HALT_AFTER);
        @(posedge clk);
        #2;
        halt_i = 1'b1;
        repeat (HALT_CYCLES) @(posedge clk);
        #2;
        halt_i = 1'b0;

        wait (obs_count >= EXP_COMMITS);
        repeat (4) @(posedge clk);
        $display("Observed %0d commits for %0d expected, %0d errors",
                 obs_count, EXP_COMMITS, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
